//--- common/arm_isa_pkg.sv
package arm_isa_pkg;

    // instruction class field
    localparam int OP_CLASS_MSB = 27;
    localparam int OP_CLASS_LSB = 26;

    typedef enum logic [1:0] {
        OP_DP  = 2'b00,
        OP_MEM = 2'b01,
        OP_BR  = 2'b10
    } op_class_t;

    // data processing opcodes
    localparam int OPCODE_MSB = 24;
    localparam int OPCODE_LSB = 21;
    localparam logic [3:0] DP_AND = 4'b0000;
    localparam logic [3:0] DP_EOR = 4'b0001;
    localparam logic [3:0] DP_SUB = 4'b0010;
    localparam logic [3:0] DP_ADD = 4'b0100;
    localparam logic [3:0] DP_ORR = 4'b1100;
    localparam logic [3:0] DP_MOV = 4'b1101;

    // single bit flags
    localparam int IMM_FLAG_BIT = 25;
    localparam int LOAD_BIT     = 20;

    // register fields
    localparam int RN_MSB = 19;
    localparam int RN_LSB = 16;
    localparam int RD_MSB = 15;
    localparam int RD_LSB = 12;
    localparam int RM_MSB = 3;
    localparam int RM_LSB = 0;

    // shifter operand, immediate amount only
    localparam int SHAMT_MSB  = 11;
    localparam int SHAMT_LSB  = 7;
    localparam int SHAMT_W    = SHAMT_MSB - SHAMT_LSB + 1;
    localparam int SHKIND_MSB = 6;
    localparam int SHKIND_LSB = 5;

    typedef enum logic [1:0] {
        SH_LSL = 2'b00,
        SH_LSR = 2'b01,
        SH_ASR = 2'b10,
        SH_ROR = 2'b11
    } shift_kind_t;

    // immediate widths
    localparam int IMM8_W      = 8;
    localparam int IMM12_W     = 12;
    localparam int BR_OFFSET_W = 24;

    typedef enum logic [2:0] {
        ALU_AND,
        ALU_EOR,
        ALU_SUB,
        ALU_ADD,
        ALU_ORR,
        ALU_PASS_B
    } alu_op_t;

endpackage

//--- common/core_pkg.sv
package core_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 4;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // operand source in execute
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_WB   = 2'b01,
        FWD_MEM  = 2'b10
    } fwd_sel_t;

    localparam int        NUM_REGS = 16;
    localparam reg_addr_t PC_REG   = 4'd15;
    localparam word_t     RESET_PC = 32'h0000_0000;
    localparam word_t     PC_STEP  = 32'd4;

endpackage

//--- verilog/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage
    import core_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  stall_f,
    input  logic  branch_take_e,
    input  word_t branch_target_e,
    output word_t pc_f,
    output word_t pc_plus4_f
);

    word_t pc_next;

    assign pc_plus4_f = pc_f + PC_STEP;

    // taken branch wins over a load-use stall
    assign pc_next = branch_take_e ? branch_target_e : pc_plus4_f;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc_f <= RESET_PC;
        end else if (branch_take_e || !stall_f) begin
            pc_f <= pc_next;
        end
    end

endmodule

//--- decode/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder
    import core_pkg::*;
    import arm_isa_pkg::*;
(
    input  word_t   instr_d,
    input  logic    valid_d,
    output logic    reg_write,
    output logic    mem_to_reg,
    output logic    mem_write,
    output logic    branch,
    output logic    alu_src,
    output logic    shift_en,
    output alu_op_t alu_op,
    output word_t   ext_imm
);

    op_class_t op_class;
    logic      is_dp;
    logic      is_mem;
    logic      is_load;
    logic      imm_flag;
    logic      rd_is_pc;

    assign op_class = op_class_t'(instr_d[OP_CLASS_MSB:OP_CLASS_LSB]);
    assign is_dp    = valid_d && (op_class == OP_DP);
    assign is_mem   = valid_d && (op_class == OP_MEM);
    assign is_load  = instr_d[LOAD_BIT];
    assign imm_flag = instr_d[IMM_FLAG_BIT];
    assign rd_is_pc = (instr_d[RD_MSB:RD_LSB] == PC_REG);

    // no result ever goes to r15
    assign reg_write  = (is_dp || (is_mem && is_load)) && !rd_is_pc;
    assign mem_to_reg = is_mem && is_load;
    assign mem_write  = is_mem && !is_load;
    assign branch     = valid_d && (op_class == OP_BR);
    assign alu_src    = is_mem || branch || (is_dp && imm_flag);
    assign shift_en   = is_dp && !imm_flag;

    always_comb begin
        alu_op = ALU_ADD;
        if (op_class == OP_DP) begin
            case (instr_d[OPCODE_MSB:OPCODE_LSB])
                DP_AND:  alu_op = ALU_AND;
                DP_EOR:  alu_op = ALU_EOR;
                DP_SUB:  alu_op = ALU_SUB;
                DP_ADD:  alu_op = ALU_ADD;
                DP_ORR:  alu_op = ALU_ORR;
                DP_MOV:  alu_op = ALU_PASS_B;
                default: alu_op = ALU_PASS_B;
            endcase
        end
    end

    always_comb begin
        case (op_class)
            OP_MEM:  ext_imm = {{(WORD_W-IMM12_W){1'b0}}, instr_d[IMM12_W-1:0]};
            // word offset, sign extended
            OP_BR:   ext_imm = {{(WORD_W-BR_OFFSET_W-2){instr_d[BR_OFFSET_W-1]}},
                                instr_d[BR_OFFSET_W-1:0], 2'b00};
            default: ext_imm = {{(WORD_W-IMM8_W){1'b0}}, instr_d[IMM8_W-1:0]};
        endcase
    end

endmodule

//--- decode/reg_file.sv
`timescale 1ns/1ps

module reg_file
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      we,
    input  reg_addr_t wa,
    input  word_t     wd,
    input  reg_addr_t ra1,
    input  reg_addr_t ra2,
    input  word_t     r15,
    output word_t     rd1,
    output word_t     rd2
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != PC_REG)) begin
            regs[wa] <= wd;
        end
    end

    // pc read first, then the write in flight
    assign rd1 = (ra1 == PC_REG) ? r15 :
                 (we && (ra1 == wa)) ? wd : regs[ra1];
    assign rd2 = (ra2 == PC_REG) ? r15 :
                 (we && (ra2 == wa)) ? wd : regs[ra2];

endmodule

//--- decode/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
    import core_pkg::*;
    import arm_isa_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               stall_d,
    input  logic               flush_d,
    input  word_t              instr_f,
    input  word_t              pc_plus4_f,
    input  logic               reg_write_w,
    input  reg_addr_t          wa3_w,
    input  word_t              result_w,
    output logic               reg_write_d,
    output logic               mem_to_reg_d,
    output logic               mem_write_d,
    output logic               branch_d,
    output logic               alu_src_d,
    output logic               shift_en_d,
    output alu_op_t            alu_op_d,
    output word_t              rd1_d,
    output word_t              rd2_d,
    output word_t              ext_imm_d,
    output reg_addr_t          ra1_d,
    output reg_addr_t          ra2_d,
    output reg_addr_t          wa3_d,
    output logic [SHAMT_W-1:0] shift_amt_d,
    output shift_kind_t        shift_kind_d,
    output logic               valid_d
);

    word_t instr_d;
    word_t pc_plus4_d;
    word_t pc_plus8_d;

    ////////////////////////////////////////////////////////////
    // fetch to decode register

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_d <= 1'b0;
        end else if (flush_d) begin
            valid_d <= 1'b0;
        end else if (!stall_d) begin
            valid_d <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_d) begin
            instr_d    <= instr_f;
            pc_plus4_d <= pc_plus4_f;
        end
    end

    ////////////////////////////////////////////////////////////
    // control and operands

    instr_decoder u_decoder (
        .instr_d    (instr_d),
        .valid_d    (valid_d),
        .reg_write  (reg_write_d),
        .mem_to_reg (mem_to_reg_d),
        .mem_write  (mem_write_d),
        .branch     (branch_d),
        .alu_src    (alu_src_d),
        .shift_en   (shift_en_d),
        .alu_op     (alu_op_d),
        .ext_imm    (ext_imm_d)
    );

    // r15 reads two words ahead
    assign pc_plus8_d = pc_plus4_d + PC_STEP;

    // branches add to the pc, stores read their data from rd
    assign ra1_d = branch_d ? PC_REG : instr_d[RN_MSB:RN_LSB];
    assign ra2_d = mem_write_d ? instr_d[RD_MSB:RD_LSB] : instr_d[RM_MSB:RM_LSB];
    assign wa3_d = instr_d[RD_MSB:RD_LSB];

    assign shift_amt_d  = instr_d[SHAMT_MSB:SHAMT_LSB];
    assign shift_kind_d = shift_kind_t'(instr_d[SHKIND_MSB:SHKIND_LSB]);

    reg_file u_reg_file (
        .clk   (clk),
        .reset (reset),
        .we    (reg_write_w),
        .wa    (wa3_w),
        .wd    (result_w),
        .ra1   (ra1_d),
        .ra2   (ra2_d),
        .r15   (pc_plus8_d),
        .rd1   (rd1_d),
        .rd2   (rd2_d)
    );

endmodule

//--- execute/barrel_shifter.sv
`timescale 1ns/1ps

module barrel_shifter
    import core_pkg::*;
    import arm_isa_pkg::*;
(
    input  word_t              value,
    input  logic [SHAMT_W-1:0] amount,
    input  shift_kind_t        kind,
    output word_t              result
);

    word_t ror_value;

    // zero amount gives value | 0, so it passes unchanged
    assign ror_value = (value >> amount) | (value << (WORD_W - amount));

    always_comb begin
        result = value;
        case (kind)
            SH_LSL: result = value << amount;
            SH_LSR: result = value >> amount;
            SH_ASR: result = $signed(value) >>> amount;
            SH_ROR: result = ror_value;
        endcase
    end

endmodule

//--- execute/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
    import core_pkg::*;
    import arm_isa_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               flush_e,
    input  logic               reg_write_d,
    input  logic               mem_to_reg_d,
    input  logic               mem_write_d,
    input  logic               branch_d,
    input  logic               alu_src_d,
    input  logic               shift_en_d,
    input  alu_op_t            alu_op_d,
    input  word_t              rd1_d,
    input  word_t              rd2_d,
    input  word_t              ext_imm_d,
    input  reg_addr_t          ra1_d,
    input  reg_addr_t          ra2_d,
    input  reg_addr_t          wa3_d,
    input  logic [SHAMT_W-1:0] shift_amt_d,
    input  shift_kind_t        shift_kind_d,
    input  logic               valid_d,
    input  fwd_sel_t           forward_a_e,
    input  fwd_sel_t           forward_b_e,
    input  word_t              alu_out_m,
    input  word_t              result_w,
    output logic               reg_write_e,
    output logic               mem_to_reg_e,
    output logic               mem_write_e,
    output word_t              alu_result_e,
    output word_t              write_data_e,
    output reg_addr_t          wa3_e,
    output reg_addr_t          ra1_e,
    output reg_addr_t          ra2_e,
    output logic               branch_take_e,
    output word_t              branch_target_e
);

    logic               valid_e;
    logic               branch_e;
    logic               alu_src_e;
    logic               shift_en_e;
    alu_op_t            alu_op_e;
    word_t              rd1_e;
    word_t              rd2_e;
    word_t              ext_imm_e;
    logic [SHAMT_W-1:0] shift_amt_e;
    shift_kind_t        shift_kind_e;
    word_t              src_a;
    word_t              src_b;
    word_t              shifted_b;

    ////////////////////////////////////////////////////////////
    // decode to execute register

    // a flush turns the slot into a bubble
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_e      <= 1'b0;
            reg_write_e  <= 1'b0;
            mem_to_reg_e <= 1'b0;
            mem_write_e  <= 1'b0;
            branch_e     <= 1'b0;
        end else begin
            valid_e      <= valid_d && !flush_e;
            reg_write_e  <= reg_write_d && !flush_e;
            mem_to_reg_e <= mem_to_reg_d && !flush_e;
            mem_write_e  <= mem_write_d && !flush_e;
            branch_e     <= branch_d && !flush_e;
        end
    end

    always_ff @(posedge clk) begin
        alu_src_e    <= alu_src_d;
        shift_en_e   <= shift_en_d;
        alu_op_e     <= alu_op_d;
        rd1_e        <= rd1_d;
        rd2_e        <= rd2_d;
        ext_imm_e    <= ext_imm_d;
        ra1_e        <= ra1_d;
        ra2_e        <= ra2_d;
        wa3_e        <= wa3_d;
        shift_amt_e  <= shift_amt_d;
        shift_kind_e <= shift_kind_d;
    end

    ////////////////////////////////////////////////////////////
    // operands and ALU

    function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_value, word_t mem_value,
                                      word_t wb_value);
        case (sel)
            FWD_MEM: return mem_value;
            FWD_WB:  return wb_value;
            default: return reg_value;
        endcase
    endfunction

    assign src_a        = fwd_mux(forward_a_e, rd1_e, alu_out_m, result_w);
    assign write_data_e = fwd_mux(forward_b_e, rd2_e, alu_out_m, result_w);

    barrel_shifter u_shifter (
        .value  (write_data_e),
        .amount (shift_amt_e),
        .kind   (shift_kind_e),
        .result (shifted_b)
    );

    assign src_b = alu_src_e ? ext_imm_e : (shift_en_e ? shifted_b : write_data_e);

    always_comb begin
        case (alu_op_e)
            ALU_AND: alu_result_e = src_a & src_b;
            ALU_EOR: alu_result_e = src_a ^ src_b;
            ALU_SUB: alu_result_e = src_a - src_b;
            ALU_ADD: alu_result_e = src_a + src_b;
            ALU_ORR: alu_result_e = src_a | src_b;
            default: alu_result_e = src_b;
        endcase
    end

    // branches add the offset to r15 through the ALU
    assign branch_take_e   = branch_e && valid_e;
    assign branch_target_e = alu_result_e;

endmodule

//--- verilog/mem_wb_stages.sv
`timescale 1ns/1ps

module mem_wb_stages
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      reg_write_e,
    input  logic      mem_to_reg_e,
    input  logic      mem_write_e,
    input  word_t     alu_result_e,
    input  word_t     write_data_e,
    input  reg_addr_t wa3_e,
    input  word_t     data_rdata,
    output logic      reg_write_m,
    output logic      mem_write_m,
    output word_t     alu_out_m,
    output word_t     write_data_m,
    output reg_addr_t wa3_m,
    output logic      reg_write_w,
    output reg_addr_t wa3_w,
    output word_t     result_w
);

    logic  mem_to_reg_m;
    logic  mem_to_reg_w;
    word_t read_data_w;
    word_t alu_out_w;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            reg_write_m  <= 1'b0;
            mem_to_reg_m <= 1'b0;
            mem_write_m  <= 1'b0;
            reg_write_w  <= 1'b0;
            mem_to_reg_w <= 1'b0;
        end else begin
            reg_write_m  <= reg_write_e;
            mem_to_reg_m <= mem_to_reg_e;
            mem_write_m  <= mem_write_e;
            reg_write_w  <= reg_write_m;
            mem_to_reg_w <= mem_to_reg_m;
        end
    end

    // memory stage
    always_ff @(posedge clk) begin
        alu_out_m    <= alu_result_e;
        write_data_m <= write_data_e;
        wa3_m        <= wa3_e;
    end

    // write-back stage, read data arrives in the memory cycle
    always_ff @(posedge clk) begin
        read_data_w <= data_rdata;
        alu_out_w   <= alu_out_m;
        wa3_w       <= wa3_m;
    end

    assign result_w = mem_to_reg_w ? read_data_w : alu_out_w;

endmodule

//--- verilog/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit
    import core_pkg::*;
(
    input  reg_addr_t ra1_d,
    input  reg_addr_t ra2_d,
    input  reg_addr_t ra1_e,
    input  reg_addr_t ra2_e,
    input  reg_addr_t wa3_e,
    input  reg_addr_t wa3_m,
    input  reg_addr_t wa3_w,
    input  logic      mem_to_reg_e,
    input  logic      reg_write_m,
    input  logic      reg_write_w,
    input  logic      branch_take_e,
    output logic      stall_f,
    output logic      stall_d,
    output logic      flush_d,
    output logic      flush_e,
    output fwd_sel_t  forward_a_e,
    output fwd_sel_t  forward_b_e
);

    logic load_use;

    // youngest producer first
    function automatic fwd_sel_t fwd_select(reg_addr_t ra, logic we_m, reg_addr_t wa_m,
                                            logic we_w, reg_addr_t wa_w);
        if (we_m && (wa_m == ra)) begin
            return FWD_MEM;
        end else if (we_w && (wa_w == ra)) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign forward_a_e = fwd_select(ra1_e, reg_write_m, wa3_m, reg_write_w, wa3_w);
    assign forward_b_e = fwd_select(ra2_e, reg_write_m, wa3_m, reg_write_w, wa3_w);

    // load result not ready until write-back
    assign load_use = mem_to_reg_e && ((ra1_d == wa3_e) || (ra2_d == wa3_e));

    assign stall_f = load_use;
    assign stall_d = load_use;
    assign flush_d = branch_take_e;
    assign flush_e = load_use || branch_take_e;

endmodule

//--- verilog/arm_pipeline.sv
`timescale 1ns/1ps

module arm_pipeline
    import core_pkg::*;
    import arm_isa_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    output word_t instr_addr,
    input  word_t instr,
    output word_t data_addr,
    output word_t data_wdata,
    output logic  data_we,
    input  word_t data_rdata
);

    // hazard control
    logic        stall_f, stall_d, flush_d, flush_e;
    fwd_sel_t    forward_a_e, forward_b_e;

    // fetch
    word_t       pc_f, pc_plus4_f;

    // decode
    logic        reg_write_d, mem_to_reg_d, mem_write_d, branch_d;
    logic        alu_src_d, shift_en_d, valid_d;
    alu_op_t     alu_op_d;
    word_t       rd1_d, rd2_d, ext_imm_d;
    reg_addr_t   ra1_d, ra2_d, wa3_d;
    logic [SHAMT_W-1:0] shift_amt_d;
    shift_kind_t shift_kind_d;

    // execute
    logic        reg_write_e, mem_to_reg_e, mem_write_e, branch_take_e;
    word_t       alu_result_e, write_data_e, branch_target_e;
    reg_addr_t   wa3_e, ra1_e, ra2_e;

    // memory and write-back
    logic        reg_write_m, mem_write_m, reg_write_w;
    word_t       alu_out_m, write_data_m, result_w;
    reg_addr_t   wa3_m, wa3_w;

    assign instr_addr = pc_f;
    assign data_addr  = alu_out_m;
    assign data_wdata = write_data_m;
    assign data_we    = mem_write_m;

    ////////////////////////////////////////////////////////////
    // stages

    fetch_stage u_fetch (
        .clk (clk), .reset (reset), .stall_f (stall_f),
        .branch_take_e (branch_take_e), .branch_target_e (branch_target_e),
        .pc_f (pc_f), .pc_plus4_f (pc_plus4_f)
    );

    decode_stage u_decode (
        .clk (clk), .reset (reset), .stall_d (stall_d), .flush_d (flush_d),
        .instr_f (instr), .pc_plus4_f (pc_plus4_f),
        .reg_write_w (reg_write_w), .wa3_w (wa3_w), .result_w (result_w),
        .reg_write_d (reg_write_d), .mem_to_reg_d (mem_to_reg_d),
        .mem_write_d (mem_write_d), .branch_d (branch_d),
        .alu_src_d (alu_src_d), .shift_en_d (shift_en_d), .alu_op_d (alu_op_d),
        .rd1_d (rd1_d), .rd2_d (rd2_d), .ext_imm_d (ext_imm_d),
        .ra1_d (ra1_d), .ra2_d (ra2_d), .wa3_d (wa3_d),
        .shift_amt_d (shift_amt_d), .shift_kind_d (shift_kind_d), .valid_d (valid_d)
    );

    execute_stage u_execute (
        .clk (clk), .reset (reset), .flush_e (flush_e),
        .reg_write_d (reg_write_d), .mem_to_reg_d (mem_to_reg_d),
        .mem_write_d (mem_write_d), .branch_d (branch_d),
        .alu_src_d (alu_src_d), .shift_en_d (shift_en_d), .alu_op_d (alu_op_d),
        .rd1_d (rd1_d), .rd2_d (rd2_d), .ext_imm_d (ext_imm_d),
        .ra1_d (ra1_d), .ra2_d (ra2_d), .wa3_d (wa3_d),
        .shift_amt_d (shift_amt_d), .shift_kind_d (shift_kind_d), .valid_d (valid_d),
        .forward_a_e (forward_a_e), .forward_b_e (forward_b_e),
        .alu_out_m (alu_out_m), .result_w (result_w),
        .reg_write_e (reg_write_e), .mem_to_reg_e (mem_to_reg_e),
        .mem_write_e (mem_write_e), .alu_result_e (alu_result_e),
        .write_data_e (write_data_e), .wa3_e (wa3_e), .ra1_e (ra1_e), .ra2_e (ra2_e),
        .branch_take_e (branch_take_e), .branch_target_e (branch_target_e)
    );

    mem_wb_stages u_mem_wb (
        .clk (clk), .reset (reset),
        .reg_write_e (reg_write_e), .mem_to_reg_e (mem_to_reg_e),
        .mem_write_e (mem_write_e), .alu_result_e (alu_result_e),
        .write_data_e (write_data_e), .wa3_e (wa3_e), .data_rdata (data_rdata),
        .reg_write_m (reg_write_m), .mem_write_m (mem_write_m),
        .alu_out_m (alu_out_m), .write_data_m (write_data_m), .wa3_m (wa3_m),
        .reg_write_w (reg_write_w), .wa3_w (wa3_w), .result_w (result_w)
    );

    hazard_unit u_hazard (
        .ra1_d (ra1_d), .ra2_d (ra2_d), .ra1_e (ra1_e), .ra2_e (ra2_e),
        .wa3_e (wa3_e), .wa3_m (wa3_m), .wa3_w (wa3_w),
        .mem_to_reg_e (mem_to_reg_e), .reg_write_m (reg_write_m),
        .reg_write_w (reg_write_w), .branch_take_e (branch_take_e),
        .stall_f (stall_f), .stall_d (stall_d), .flush_d (flush_d), .flush_e (flush_e),
        .forward_a_e (forward_a_e), .forward_b_e (forward_b_e)
    );

endmodule

//--- bench/arm_pipeline_tb.sv
`timescale 1ns/1ps

module arm_pipeline_tb
    import core_pkg::*;
    import arm_isa_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 3;
    localparam int PROG_LEN     = 33;
    localparam int IMEM_WORDS   = 64;
    localparam int DMEM_WORDS   = 64;
    localparam int NUM_STORES   = 14;

    logic   clk = 1'b0;
    logic   reset;
    word_t  instr_addr;
    word_t  instr;
    word_t  data_addr;
    word_t  data_wdata;
    logic   data_we;
    word_t  data_rdata;

    word_t  imem [IMEM_WORDS];
    word_t  dmem [DMEM_WORDS];
    word_t  dmem_init [DMEM_WORDS];
    word_t  prog [PROG_LEN];
    word_t  exp_addr [NUM_STORES];
    word_t  exp_data [NUM_STORES];
    int     exp_mem_idx [NUM_STORES];
    integer seed;
    int     store_idx;

    arm_pipeline u_dut (
        .clk        (clk),
        .reset      (reset),
        .instr_addr (instr_addr),
        .instr      (instr),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_we    (data_we),
        .data_rdata (data_rdata)
    );

    ////////////////////////////////////////////////////////////
    // clock and memory models

    always #(CLK_PERIOD / 2) clk = ~clk;

    // word addressed, reads are combinational
    assign instr      = imem[instr_addr[7:2]];
    assign data_rdata = dmem[data_addr[7:2]];

    always @(posedge clk) begin
        if (data_we) begin
            dmem[data_addr[7:2]] <= data_wdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // instruction encoding, condition field always AL

    function automatic word_t dp_imm_word(logic [3:0] op, reg_addr_t rn, reg_addr_t rd,
                                          logic [7:0] imm);
        return {4'hE, 2'b00, 1'b1, op, 1'b0, rn, rd, 4'h0, imm};
    endfunction

    function automatic word_t dp_reg_word(logic [3:0] op, reg_addr_t rn, reg_addr_t rd,
                                          reg_addr_t rm, logic [4:0] amt, shift_kind_t kind);
        return {4'hE, 2'b00, 1'b0, op, 1'b0, rn, rd, amt, kind, 1'b0, rm};
    endfunction

    // pre-indexed, offset added
    function automatic word_t mem_word(logic load, reg_addr_t rn, reg_addr_t rd,
                                       logic [11:0] off);
        return {4'hE, 2'b01, 1'b0, 4'b1100, load, rn, rd, off};
    endfunction

    function automatic word_t branch_word(logic [23:0] off);
        return {4'hE, 3'b101, 1'b0, off};
    endfunction

    ////////////////////////////////////////////////////////////
    // program and expected stores

    task automatic load_program();
        // r0 stays zero and serves as the base register
        prog[0]  = dp_imm_word(DP_MOV, 4'd0, 4'd1, 8'h5A);
        prog[1]  = dp_imm_word(DP_ADD, 4'd1, 4'd2, 8'h10);
        prog[2]  = dp_imm_word(DP_SUB, 4'd2, 4'd3, 8'h0A);
        prog[3]  = dp_reg_word(DP_AND, 4'd3, 4'd4, 4'd1, 5'd0, SH_LSL);
        // r3 two instructions back, from write-back
        prog[4]  = dp_reg_word(DP_EOR, 4'd4, 4'd5, 4'd3, 5'd0, SH_LSL);
        prog[5]  = dp_imm_word(DP_ORR, 4'd5, 4'd6, 8'h81);
        prog[6]  = mem_word(1'b0, 4'd0, 4'd2, 12'h080);
        prog[7]  = mem_word(1'b0, 4'd0, 4'd3, 12'h084);
        prog[8]  = mem_word(1'b0, 4'd0, 4'd4, 12'h088);
        prog[9]  = mem_word(1'b0, 4'd0, 4'd5, 12'h08C);
        prog[10] = mem_word(1'b0, 4'd0, 4'd6, 12'h090);
        // shifts on a value with its top bit set
        prog[11] = dp_imm_word(DP_MOV, 4'd0, 4'd7, 8'hF0);
        prog[12] = dp_reg_word(DP_MOV, 4'd0, 4'd8, 4'd7, 5'd24, SH_LSL);
        prog[13] = dp_reg_word(DP_MOV, 4'd0, 4'd9, 4'd8, 5'd4, SH_LSR);
        prog[14] = dp_reg_word(DP_MOV, 4'd0, 4'd10, 4'd8, 5'd4, SH_ASR);
        prog[15] = dp_reg_word(DP_ADD, 4'd1, 4'd12, 4'd8, 5'd0, SH_LSL);
        // low byte of r12 wraps to the top
        prog[16] = dp_reg_word(DP_ADD, 4'd0, 4'd11, 4'd12, 5'd8, SH_ROR);
        prog[17] = dp_reg_word(DP_ORR, 4'd0, 4'd13, 4'd8, 5'd0, SH_ROR);
        prog[18] = mem_word(1'b0, 4'd0, 4'd8, 12'h094);
        prog[19] = mem_word(1'b0, 4'd0, 4'd9, 12'h098);
        prog[20] = mem_word(1'b0, 4'd0, 4'd10, 12'h09C);
        prog[21] = mem_word(1'b0, 4'd0, 4'd11, 12'h0A0);
        prog[22] = mem_word(1'b0, 4'd0, 4'd12, 12'h0A4);
        prog[23] = mem_word(1'b0, 4'd0, 4'd13, 12'h0A8);
        // load then immediate use, word index 5
        prog[24] = mem_word(1'b1, 4'd0, 4'd1, 12'h014);
        prog[25] = dp_imm_word(DP_ADD, 4'd1, 4'd2, 8'h33);
        prog[26] = mem_word(1'b0, 4'd0, 4'd2, 12'h0AC);
        // pc 0x6C, r15 0x74, target 0x78
        prog[27] = branch_word(24'd1);
        prog[28] = mem_word(1'b0, 4'd0, 4'd6, 12'h0B0);
        prog[29] = mem_word(1'b0, 4'd0, 4'd6, 12'h0B4);
        prog[30] = mem_word(1'b0, 4'd0, 4'd3, 12'h0B8);
        prog[31] = mem_word(1'b0, 4'd0, PC_REG, 12'h0BC);
        // halt by branching to itself
        prog[32] = branch_word(24'hFF_FFFE);
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = (i < PROG_LEN) ? prog[i] : branch_word(24'hFF_FFFE);
        end
    endtask

    task automatic set_store(int idx, word_t addr, word_t data, int mem_idx);
        exp_addr[idx]    = addr;
        exp_data[idx]    = data;
        exp_mem_idx[idx] = mem_idx;
    endtask

    task automatic load_expectations();
        set_store(0, 32'h80, 32'h0000_006A, -1);
        set_store(1, 32'h84, 32'h0000_0060, -1);
        set_store(2, 32'h88, 32'h0000_0040, -1);
        set_store(3, 32'h8C, 32'h0000_0020, -1);
        set_store(4, 32'h90, 32'h0000_00A1, -1);
        set_store(5, 32'h94, 32'hF000_0000, -1);
        set_store(6, 32'h98, 32'h0F00_0000, -1);
        set_store(7, 32'h9C, 32'hFF00_0000, -1);
        set_store(8, 32'hA0, 32'h5AF0_0000, -1);
        set_store(9, 32'hA4, 32'hF000_005A, -1);
        set_store(10, 32'hA8, 32'hF000_0000, -1);
        // loaded word plus the immediate
        set_store(11, 32'hAC, 32'h0000_0033, 5);
        set_store(12, 32'hB8, 32'h0000_0060, -1);
        set_store(13, 32'hBC, 32'h0000_0084, -1);
    endtask

    task automatic fill_data_memory();
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = $random(seed);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // checks

    task automatic report_failure(string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("Errors found");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_store(word_t addr, word_t data);
        if ((data_addr !== addr) || (data_wdata !== data)) begin
            report_failure($sformatf("store %0d wrote %h to %h, expected %h to %h",
                                     store_idx, data_wdata, data_addr, data, addr));
        end
    endtask

    task automatic check_pc(word_t addr);
        if (instr_addr !== addr) begin
            report_failure($sformatf("instr_addr is %h, expected %h", instr_addr, addr));
        end
    endtask

    task automatic check_we(logic expected, string when);
        if (data_we !== expected) begin
            report_failure($sformatf("data_we is %b %s, expected %b", data_we, when, expected));
        end
    endtask

    // walks the store table as stores show up
    always @(negedge clk) begin
        word_t expected;
        if (reset) begin
            check_we(1'b0, "during reset");
        end else if (data_we) begin
            if (store_idx >= NUM_STORES) begin
                report_failure($sformatf("unexpected store of %h to %h", data_wdata, data_addr));
            end else begin
                expected = exp_data[store_idx];
                if (exp_mem_idx[store_idx] >= 0) begin
                    expected = dmem_init[exp_mem_idx[store_idx]] + expected;
                end
                check_store(exp_addr[store_idx], expected);
                store_idx = store_idx + 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // main sequence and watchdog

    initial begin
        reset     = 1'b1;
        seed      = 32'hb301_d873;
        store_idx = 0;
        load_program();
        load_expectations();
        fill_data_memory();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_pc(RESET_PC);
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem_init[i] = dmem[i];
        end
        wait (store_idx == NUM_STORES);
        // stray stores after the last one still get caught
        repeat (8) @(negedge clk);
        $display("No errors");
        $finish;
    end

    initial begin
        #(PROG_LEN * 10 * CLK_PERIOD);
        $display("Simulation timed out with %0d of %0d stores seen", store_idx, NUM_STORES);
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- verilog.f
common/arm_isa_pkg.sv
common/core_pkg.sv
verilog/fetch_stage.sv
decode/instr_decoder.sv
decode/reg_file.sv
decode/decode_stage.sv
execute/barrel_shifter.sv
execute/execute_stage.sv
verilog/mem_wb_stages.sv
verilog/hazard_unit.sv
verilog/arm_pipeline.sv
bench/arm_pipeline_tb.sv

//--- Bender.yml
package:
  name: arm_pipeline

sources:
  - common/arm_isa_pkg.sv
  - common/core_pkg.sv
  - verilog/fetch_stage.sv
  - decode/instr_decoder.sv
  - decode/reg_file.sv
  - decode/decode_stage.sv
  - execute/barrel_shifter.sv
  - execute/execute_stage.sv
  - verilog/mem_wb_stages.sv
  - verilog/hazard_unit.sv
  - verilog/arm_pipeline.sv
  - target: test
    files:
      - bench/arm_pipeline_tb.sv
